// ==== flist.f ====
+incdir+verilog
verilog/sdctrl_pkg.sv
verilog/sdctrl_crc7.sv
verilog/sdctrl_cmd_tx.sv
verilog/sdctrl_cmd_rx.sv
verilog/sdctrl_cmd_ctrl.sv
verilog/sdctrl_regs.sv
verilog/sdctrl_top.sv
sim/tb_sdctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sd command path testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_sdctrl -o sim_sdctrl
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_sdctrl 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== sim/sdctrl_patterns.txt ====
# columns (hex): W addr data | R addr expect | K div | C index arg rindex rarg mode
# mode is ok, badcrc, badend or silent
# reset values
R 00 00000004
R 08 00000040
R 14 00000000
R 04 00000100
# readback and read-only registers
W 00 00000007
R 00 00000007
W 08 00000020
R 08 00000020
W 10 DEADBEEF
R 10 DEADBEEF
W 18 FFFFFFFF
R 18 00000000
W 1C 12345678
R 1C 00000000
W 14 FFFFFFFF
R 14 00000000
R 24 00000000
# sd clock period and disable
K 4
K 0
K 9
# commands at div 1
W 00 00000001
W 04 00000001
R 04 00000101
C 00 00000000 3F FFFFFFFF ok
C 11 00001234 11 00000900 ok
C 08 000001AA 08 000001AA badcrc
C 37 CAFE0001 37 00FF00FF badend
C 0D 12340000 0D 00000000 silent
C 29 0F0F0F0F 29 A5A55A5A ok
R 0C 00000029

// ==== sim/tb_sdctrl.sv ====
/* testbench for the sd command path with clock and reset, register port tasks,
   card responder with reference crc7 and pattern file player */
`include "sdctrl_cfg.svh"

module tb_sdctrl;

    localparam int         WAIT_LIMIT = 1000;   // cycles per wait loop
    localparam int         HUNT_LIMIT = 100;    // sd clocks before a frame must start
    localparam logic [3:0] ST_DONE    = 4'd3;

    logic        i_clk;
    logic        i_nrst;
    logic        i_req;
    logic        i_we;
    logic [7:0]  i_addr;
    logic [31:0] i_wdata;
    logic        o_ack;
    logic [31:0] o_rdata;
    logic        o_sd_clk;
    logic        o_sd_cmd;
    logic        i_sd_cmd;

    int          cyc = 0;                       // free running cycle count
    logic [31:0] last_resp;                     // expected RESP after each command
    logic [31:0] last_resp_arg;

    sdctrl_top uut (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_req(i_req), .i_we(i_we), .i_addr(i_addr), .i_wdata(i_wdata),
        .o_ack(o_ack), .o_rdata(o_rdata),
        .o_sd_clk(o_sd_clk), .o_sd_cmd(o_sd_cmd), .i_sd_cmd(i_sd_cmd)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    always @(posedge i_clk) cyc <= cyc + 1;

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // reference crc7 of x^7 + x^3 + 1 fed msb first
    function automatic logic [6:0] crc7_ref(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        int         i;
        crc = '0;
        for (i = 39; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (o_ack !== level) begin
            @(negedge i_clk);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout: register port ack did not reach %0b", level);
                abort_run();
            end
        end
    endtask

    // four-phase access entered and left on a falling clock edge
    task automatic bus_access(input logic we, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        i_req   = 1'b1;
        i_we    = we;
        i_addr  = addr;
        i_wdata = wdata;
        wait_ack(1'b1);
        rdata   = o_rdata;                      // valid while ack high
        i_req   = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] discard;
        bus_access(1'b1, addr, data, discard);
    endtask

    task automatic read_check(input string name, input logic [7:0] addr,
                              input logic [31:0] exp);
        logic [31:0] data;
        bus_access(1'b0, addr, 32'h0, data);
        check(name, 64'(data), 64'(exp));
    endtask

    // sampled on falling i_clk so o_sd_clk is settled
    task automatic wait_sd_edge(input logic rising, output int waited);
        logic prev;
        logic seen;
        prev   = o_sd_clk;
        seen   = 1'b0;
        waited = 0;
        while (!seen) begin
            @(negedge i_clk);
            waited++;
            seen = (prev != rising) && (o_sd_clk == rising);
            prev = o_sd_clk;
            if (!seen && waited > WAIT_LIMIT) begin
                $display("timeout: no %0s edge on o_sd_clk", rising ? "rising" : "falling");
                abort_run();
            end
        end
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        int          t0;
        t0 = cyc;
        st = 32'h1;
        while (st[0]) begin                     // busy bit
            bus_access(1'b0, `SDCTRL_REG_STATUS, 32'h0, st);
            if (st[0] && (cyc - t0) > WAIT_LIMIT) begin
                $display("timeout: command still busy");
                abort_run();
            end
        end
    endtask

    task automatic card_collect(output logic [47:0] frame);
        int n;
        int hunts;
        int i;
        hunts = 0;
        frame = '1;
        do begin                                // hunt for the start bit
            wait_sd_edge(1'b1, n);
            hunts++;
            if (o_sd_cmd !== 1'b0 && hunts > HUNT_LIMIT) begin
                $display("timeout: no command frame on o_sd_cmd");
                abort_run();
            end
        end while (o_sd_cmd !== 1'b0);
        frame[47] = 1'b0;
        for (i = 46; i >= 0; i--) begin
            wait_sd_edge(1'b1, n);
            frame[i] = o_sd_cmd;
        end
    endtask

    task automatic card_respond(input logic [47:0] resp);
        int n;
        int i;
        repeat (2) wait_sd_edge(1'b1, n);       // card turnaround
        for (i = 47; i >= 0; i--) begin
            wait_sd_edge(1'b0, n);
            i_sd_cmd = resp[i];
        end
        wait_sd_edge(1'b0, n);
        i_sd_cmd = 1'b1;                        // release the line
    endtask

    task automatic measure_sck(input logic [15:0] div);
        int   n;
        logic level;
        bus_write(`SDCTRL_REG_SCKDIV, {16'h0, div});
        bus_write(`SDCTRL_REG_CONTROL, 32'h1);
        wait_sd_edge(1'b1, n);
        wait_sd_edge(1'b1, n);                  // full period between rises
        check("o_sd_clk period", 64'(n), 64'(2 * (int'(div) + 1)));
        bus_write(`SDCTRL_REG_CONTROL, 32'h0);
        level = o_sd_clk;
        repeat (100) begin
            @(negedge i_clk);
            check("o_sd_clk while disabled", 64'(o_sd_clk), 64'(level));
        end
    endtask

    task automatic run_command(input logic [5:0] idx, input logic [31:0] arg,
                               input logic [5:0] ridx, input logic [31:0] rarg,
                               input logic [63:0] mode);
        logic [47:0] frame;
        logic [47:0] resp;
        logic [39:0] body;
        logic [6:0]  crc;
        logic [6:0]  crc_sent;
        logic [3:0]  err;
        body     = {2'b00, ridx, rarg};         // start 0, direction 0 from card
        crc      = crc7_ref(body);
        crc_sent = (mode == "badcrc") ? (crc ^ 7'h01) : crc;
        resp     = {body, crc_sent, mode != "badend"};
        case (mode)
            "silent": err = 4'd1;
            "badcrc": err = 4'd2;
            "badend": err = 4'd3;
            default:  err = 4'd0;
        endcase
        bus_write(`SDCTRL_REG_ARG, arg);
        fork
            begin
                card_collect(frame);
                if (mode != "silent") begin
                    card_respond(resp);
                end
            end
            begin
                bus_write(`SDCTRL_REG_CMD, {26'h0, idx});
                bus_write(`SDCTRL_REG_CMD, {26'h0, ~idx});  // lands while busy
                wait_idle();
            end
        join
        check("card frame", 64'(frame),
              64'({2'b01, idx, arg, crc7_ref({2'b01, idx, arg}), 1'b1}));
        if (mode != "silent") begin
            last_resp     = {9'h0, crc, 1'b0, crc_sent, 2'b00, ridx};
            last_resp_arg = rarg;
        end
        read_check("STATUS", `SDCTRL_REG_STATUS, {20'h0, err, ST_DONE, 4'h0});
        read_check("RESP", `SDCTRL_REG_RESP, last_resp);
        read_check("RESP_ARG", `SDCTRL_REG_RESP_ARG, last_resp_arg);
        read_check("CMD", `SDCTRL_REG_CMD, {26'h0, idx});
        repeat (100) begin                      // no second frame follows
            @(negedge i_clk);
            check("o_sd_cmd outside frame", 64'(o_sd_cmd), 64'h1);
        end
        read_check("STATUS after command", `SDCTRL_REG_STATUS, {20'h0, err, ST_DONE, 4'h0});
    endtask

    initial begin
        int               fd;
        int               code;
        logic [63:0]      op;
        logic [63:0]      mode;
        logic [8*120-1:0] line;
        logic [7:0]       addr;
        logic [31:0]      data;
        logic [15:0]      div;
        logic [5:0]       idx;
        logic [5:0]       ridx;
        logic [31:0]      arg;
        logic [31:0]      rarg;
        i_nrst        = 1'b0;
        i_req         = 1'b0;
        i_we          = 1'b0;
        i_addr        = '0;
        i_wdata       = '0;
        i_sd_cmd      = 1'b1;                   // card idle high
        last_resp     = '0;
        last_resp_arg = '0;
        repeat (4) @(negedge i_clk);
        i_nrst = 1'b1;
        @(negedge i_clk);
        check("o_ack after reset", 64'(o_ack), 64'h0);
        check("o_sd_cmd after reset", 64'(o_sd_cmd), 64'h1);
        check("o_sd_clk after reset", 64'(o_sd_clk), 64'h0);

        fd = $fopen("sim/sdctrl_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/sdctrl_patterns.txt");
            abort_run();
        end
        code = $fscanf(fd, "%s", op);
        while (code == 1) begin
            case (op)
                "#": code = $fgets(line, fd);   // comment line
                "W": begin
                    code = $fscanf(fd, "%h %h", addr, data);
                    bus_write(addr, data);
                end
                "R": begin
                    code = $fscanf(fd, "%h %h", addr, data);
                    read_check($sformatf("reg 0x%02h", addr), addr, data);
                end
                "K": begin
                    code = $fscanf(fd, "%h", div);
                    measure_sck(div);
                end
                "C": begin
                    code = $fscanf(fd, "%h %h %h %h %s", idx, arg, ridx, rarg, mode);
                    run_command(idx, arg, ridx, rarg, mode);
                end
                default: begin
                    $display("unknown operation in pattern file");
                    abort_run();
                end
            endcase
            code = $fscanf(fd, "%s", op);
        end
        $fclose(fd);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== verilog/sdctrl_cfg.svh ====
/* sd host controller configuration: field widths, frame length,
   reset values and the register map offsets */
`ifndef SDCTRL_CFG_SVH
`define SDCTRL_CFG_SVH

`define SDCTRL_ADDR_W       8       // register byte address width
`define SDCTRL_FRAME_BITS   48      // command and response frame length
`define SDCTRL_DIV_RESET    16'd4   // sd clock half period minus one
`define SDCTRL_WDOG_RESET   16'd64  // response timeout in sd clocks

`define SDCTRL_REG_SCKDIV   8'h00   // rw clock divider
`define SDCTRL_REG_CONTROL  8'h04   // rw clock enable, cmd line readback
`define SDCTRL_REG_WDOG     8'h08   // rw response watchdog
`define SDCTRL_REG_CMD      8'h0C   // rw command index, write starts command
`define SDCTRL_REG_ARG      8'h10   // rw command argument
`define SDCTRL_REG_STATUS   8'h14   // ro busy, state, error
`define SDCTRL_REG_RESP     8'h18   // ro response index and crc values
`define SDCTRL_REG_RESP_ARG 8'h1C   // ro response argument

`endif

// ==== verilog/sdctrl_cmd_ctrl.sv ====
/* command sequencer: runs transmit then receive for one command,
   latches the error and hands the response to the register block */
module sdctrl_cmd_ctrl (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic                    i_cmd_req,
    input  sdctrl_pkg::sd_frame_t   i_cmd_frame,
    output logic                    o_cmd_ack,
    output sdctrl_pkg::cmd_status_t o_status,
    output logic                    o_resp_valid,   // one cycle per response
    output sdctrl_pkg::resp_info_t  o_resp,
    output logic                    o_tx_req,
    output sdctrl_pkg::sd_frame_t   o_tx_frame,
    input  logic                    i_tx_ack,
    output logic                    o_rx_req,
    input  logic                    i_rx_ack,
    input  sdctrl_pkg::resp_info_t  i_rx_resp,
    input  sdctrl_pkg::cmd_err_e    i_rx_err
);
    import sdctrl_pkg::*;

    cmd_state_e state;
    cmd_err_e   err;
    logic       busy;
    logic       start;

    // still busy until the register block releases its request
    assign busy     = (state == SEND) || (state == WAIT_RESP) || o_cmd_ack;
    assign start    = i_cmd_req && !o_cmd_ack && ((state == IDLE) || (state == DONE));
    assign o_status = '{state: state, err: err, busy: busy};

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state        <= IDLE;
            err          <= NONE;
            o_cmd_ack    <= 1'b0;
            o_tx_req     <= 1'b0;
            o_rx_req     <= 1'b0;
            o_resp_valid <= 1'b0;
        end else begin
            o_resp_valid <= 1'b0;
            if (o_cmd_ack && !i_cmd_req) begin
                o_cmd_ack <= 1'b0;
            end
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        o_tx_req <= 1'b1;
                        err      <= NONE;
                        state    <= SEND;
                    end
                end
                SEND: begin
                    if (o_tx_req && i_tx_ack) begin
                        o_tx_req <= 1'b0;
                    end else if (!o_tx_req && !i_tx_ack) begin // tx handshake closed
                        o_rx_req <= 1'b1;
                        state    <= WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    if (o_rx_req && i_rx_ack) begin
                        o_rx_req     <= 1'b0;
                        err          <= i_rx_err;
                        o_resp_valid <= (i_rx_err != TIMEOUT);
                    end else if (!o_rx_req && !i_rx_ack) begin
                        o_cmd_ack <= 1'b1;
                        state     <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (start) begin
            o_tx_frame <= i_cmd_frame;                  // held for the whole frame
        end
        if (o_rx_req && i_rx_ack) begin
            o_resp <= i_rx_resp;
        end
    end

    a_tx_rx_exclusive: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(o_tx_req && o_rx_req));

endmodule

// ==== verilog/sdctrl_cmd_rx.sv ====
/* response deserialiser: start-bit hunt under watchdog, 47-bit shift,
   crc7 and end-bit checks */
`include "sdctrl_cfg.svh"

module sdctrl_cmd_rx (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  logic                   i_sck_pos,
    input  logic                   i_sd_cmd,
    input  sdctrl_pkg::wdog_t      i_wdog,
    input  logic                   i_req,
    output logic                   o_ack,
    output sdctrl_pkg::resp_info_t o_resp,      // valid while ack high
    output sdctrl_pkg::cmd_err_e   o_err
);
    import sdctrl_pkg::*;

    logic [`SDCTRL_FRAME_BITS-3:0] shreg;       // index, arg, crc, end
    logic [5:0] bit_cnt;                        // bits after start bit
    wdog_t      wdog_cnt;
    logic       hunt;
    logic       shift;
    logic       timeout;
    logic       start;
    logic       crc_ena;
    crc7_t      crc;

    assign start   = i_req && !o_ack && !hunt && !shift;
    assign crc_ena = i_sck_pos && ((hunt && !i_sd_cmd) ||
                     (shift && (bit_cnt < 6'(`SDCTRL_FRAME_BITS - 9))));
    assign o_resp  = '{index: shreg[45:40], arg: shreg[39:8],
                       crc_rx: shreg[7:1], crc_calc: crc};

    always_comb begin
        if (timeout) begin
            o_err = TIMEOUT;
        end else if (!shreg[0]) begin
            o_err = END_BIT;
        end else if (shreg[7:1] != crc) begin
            o_err = CRC;
        end else begin
            o_err = NONE;
        end
    end

    sdctrl_crc7 u_crc (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (start),
        .i_ena   (crc_ena),
        .i_bit   (i_sd_cmd),
        .o_crc   (crc)
    );

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            hunt     <= 1'b0;
            shift    <= 1'b0;
            timeout  <= 1'b0;
            o_ack    <= 1'b0;
            bit_cnt  <= '0;
            wdog_cnt <= '0;
        end else begin
            if (o_ack && !i_req) begin
                o_ack <= 1'b0;
            end
            if (start) begin
                hunt     <= 1'b1;
                timeout  <= 1'b0;
                wdog_cnt <= i_wdog;
            end else if (hunt && i_sck_pos) begin
                if (!i_sd_cmd) begin
                    hunt    <= 1'b0;                    // start bit seen
                    shift   <= 1'b1;
                    bit_cnt <= '0;
                end else if (wdog_cnt <= 16'd1) begin
                    hunt    <= 1'b0;
                    timeout <= 1'b1;
                    o_ack   <= 1'b1;
                end else begin
                    wdog_cnt <= wdog_cnt - 1'b1;
                end
            end else if (shift && i_sck_pos) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 6'(`SDCTRL_FRAME_BITS - 2)) begin
                    shift <= 1'b0;                      // end bit taken
                    o_ack <= 1'b1;
                end
            end
        end
    end

    // direction bit falls off the top
    always_ff @(posedge i_clk) begin
        if (shift && i_sck_pos) begin
            shreg <= {shreg[`SDCTRL_FRAME_BITS-4:0], i_sd_cmd};
        end
    end

endmodule

// ==== verilog/sdctrl_cmd_tx.sv ====
/* command frame serialiser, start and direction bits, index, argument,
   crc7 and end bit, changing on falling sd clock strobes */
`include "sdctrl_cfg.svh"

module sdctrl_cmd_tx (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  logic                  i_sck_neg,
    input  logic                  i_req,
    input  sdctrl_pkg::sd_frame_t i_frame,
    output logic                  o_ack,
    output logic                  o_sd_cmd        // idle high
);
    import sdctrl_pkg::*;

    logic [`SDCTRL_FRAME_BITS-9:0] shreg;         // start, dir, index, arg
    logic [5:0] bit_cnt;
    logic [5:0] crc_idx;
    logic       active;
    logic       start;
    logic       crc_ena;
    crc7_t      crc;

    assign start   = i_req && !o_ack && !active;
    assign crc_ena = active && i_sck_neg && (bit_cnt < 6'(`SDCTRL_FRAME_BITS - 8));
    assign crc_idx = 6'(`SDCTRL_FRAME_BITS - 2) - bit_cnt;  // crc msb first

    sdctrl_crc7 u_crc (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (start),
        .i_ena   (crc_ena),
        .i_bit   (shreg[`SDCTRL_FRAME_BITS-9]),
        .o_crc   (crc)
    );

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            active   <= 1'b0;
            bit_cnt  <= '0;
            o_ack    <= 1'b0;
            o_sd_cmd <= 1'b1;
        end else begin
            if (o_ack && !i_req) begin
                o_ack <= 1'b0;
            end
            if (start) begin
                active  <= 1'b1;
                bit_cnt <= '0;
            end else if (active && i_sck_neg) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt < 6'(`SDCTRL_FRAME_BITS - 8)) begin
                    o_sd_cmd <= shreg[`SDCTRL_FRAME_BITS-9];
                end else if (bit_cnt < 6'(`SDCTRL_FRAME_BITS - 1)) begin
                    o_sd_cmd <= crc[crc_idx[2:0]];
                end else if (bit_cnt == 6'(`SDCTRL_FRAME_BITS - 1)) begin
                    o_sd_cmd <= 1'b1;                   // end bit
                end else begin
                    active <= 1'b0;                     // strobe after end bit
                    o_ack  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (start) begin
            shreg <= {2'b01, i_frame};
        end else if (active && i_sck_neg) begin
            shreg <= {shreg[`SDCTRL_FRAME_BITS-10:0], 1'b0};
        end
    end

    a_idle_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !active |-> o_sd_cmd);

endmodule

// ==== verilog/sdctrl_crc7.sv ====
/* serial crc7 generator, polynomial x^7 + x^3 + 1 */
module sdctrl_crc7 (
    input  logic              i_clk,
    input  logic              i_nrst,
    input  logic              i_clear,    // start of frame
    input  logic              i_ena,      // one bit this cycle
    input  logic              i_bit,
    output sdctrl_pkg::crc7_t o_crc
);
    logic fb;

    assign fb = i_bit ^ o_crc[6];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_crc <= '0;
        end else if (i_clear) begin
            o_crc <= '0;
        end else if (i_ena) begin
            o_crc <= {o_crc[5:3], o_crc[2] ^ fb, o_crc[1:0], fb}; // taps at x^3 and x^0
        end
    end

endmodule

// ==== verilog/sdctrl_pkg.sv ====
/* sd host controller types: vector typedefs, command state and
   error enums, frame, response and status structs */
`include "sdctrl_cfg.svh"

package sdctrl_pkg;

    typedef logic [`SDCTRL_ADDR_W-1:0] reg_addr_t; // register byte address
    typedef logic [31:0] reg_data_t;
    typedef logic [15:0] sck_div_t;                 // half period minus one
    typedef logic [15:0] wdog_t;                    // timeout in sd clocks
    typedef logic [5:0]  cmd_index_t;
    typedef logic [31:0] cmd_arg_t;
    typedef logic [6:0]  crc7_t;

    typedef enum logic [3:0] {
        IDLE      = 4'd0,
        SEND      = 4'd1,   // frame going out on cmd
        WAIT_RESP = 4'd2,   // hunting or shifting response
        DONE      = 4'd3
    } cmd_state_e;

    typedef enum logic [3:0] {
        NONE    = 4'd0,
        TIMEOUT = 4'd1,     // no start bit within watchdog
        CRC     = 4'd2,
        END_BIT = 4'd3
    } cmd_err_e;

    typedef struct packed {
        cmd_index_t index;
        cmd_arg_t   arg;
    } sd_frame_t;

    typedef struct packed {
        cmd_index_t index;
        cmd_arg_t   arg;
        crc7_t      crc_rx;     // crc field taken from the line
        crc7_t      crc_calc;   // crc computed over first 40 bits
    } resp_info_t;

    typedef struct packed {
        cmd_state_e state;
        cmd_err_e   err;
        logic       busy;
    } cmd_status_t;

endpackage

// ==== verilog/sdctrl_regs.sv ====
/* register port slave, register file, sd clock divider with edge
   strobes, and capture of the last command response */
`include "sdctrl_cfg.svh"

module sdctrl_regs (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic                    i_req,          // four-phase host request
    input  logic                    i_we,
    input  sdctrl_pkg::reg_addr_t   i_addr,
    input  sdctrl_pkg::reg_data_t   i_wdata,
    output logic                    o_ack,
    output sdctrl_pkg::reg_data_t   o_rdata,
    input  logic                    i_sd_cmd,       // cmd line readback
    output logic                    o_sd_clk,
    output logic                    o_sck_pos,      // level rises on next edge
    output logic                    o_sck_neg,      // level falls on next edge
    output sdctrl_pkg::wdog_t       o_wdog,
    output logic                    o_cmd_req,
    output sdctrl_pkg::sd_frame_t   o_cmd_frame,
    input  logic                    i_cmd_ack,
    input  sdctrl_pkg::cmd_status_t i_status,
    input  logic                    i_resp_valid,
    input  sdctrl_pkg::resp_info_t  i_resp
);
    import sdctrl_pkg::*;

    sck_div_t   sck_div;
    sck_div_t   sck_cnt;
    logic       sck_ena;
    logic       sck_tick;       // level flips on next edge
    logic       div_wr;
    logic       wr_stb;         // first cycle of a write access
    wdog_t      wdog;
    cmd_index_t cmd_index;
    cmd_arg_t   cmd_arg;
    resp_info_t last_resp;
    reg_data_t  rdata_mux;

    assign wr_stb      = i_req && i_we && !o_ack;
    assign div_wr      = wr_stb && (i_addr == `SDCTRL_REG_SCKDIV);
    assign sck_tick    = sck_ena && (sck_cnt >= sck_div);
    assign o_sck_pos   = sck_tick && !o_sd_clk;
    assign o_sck_neg   = sck_tick && o_sd_clk;
    assign o_wdog      = wdog;
    assign o_cmd_frame = '{index: cmd_index, arg: cmd_arg};

    always_comb begin
        rdata_mux = '0;                                 // unmapped reads 0
        case (i_addr)
            `SDCTRL_REG_SCKDIV:   rdata_mux[15:0] = sck_div;
            `SDCTRL_REG_CONTROL: begin
                rdata_mux[0] = sck_ena;
                rdata_mux[8] = i_sd_cmd;
            end
            `SDCTRL_REG_WDOG:     rdata_mux[15:0] = wdog;
            `SDCTRL_REG_CMD:      rdata_mux[5:0] = cmd_index;
            `SDCTRL_REG_ARG:      rdata_mux = cmd_arg;
            `SDCTRL_REG_STATUS: begin
                rdata_mux[0]    = i_status.busy;
                rdata_mux[7:4]  = i_status.state;
                rdata_mux[11:8] = i_status.err;
            end
            `SDCTRL_REG_RESP: begin
                rdata_mux[5:0]   = last_resp.index;
                rdata_mux[14:8]  = last_resp.crc_rx;
                rdata_mux[22:16] = last_resp.crc_calc;
            end
            `SDCTRL_REG_RESP_ARG: rdata_mux = last_resp.arg;
            default:              rdata_mux = '0;
        endcase
    end

    // ack follows req one edge later in both directions
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_req;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req && !o_ack) begin
            o_rdata <= rdata_mux;                       // valid with ack
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            sck_div   <= `SDCTRL_DIV_RESET;
            sck_ena   <= 1'b0;
            wdog      <= `SDCTRL_WDOG_RESET;
            cmd_index <= '0;
            cmd_arg   <= '0;
            o_cmd_req <= 1'b0;
        end else begin
            if (o_cmd_req && i_cmd_ack) begin
                o_cmd_req <= 1'b0;                      // command finished
            end
            if (wr_stb) begin
                case (i_addr)
                    `SDCTRL_REG_SCKDIV:  sck_div <= i_wdata[15:0];
                    `SDCTRL_REG_CONTROL: sck_ena <= i_wdata[0];
                    `SDCTRL_REG_WDOG:    wdog <= i_wdata[15:0];
                    `SDCTRL_REG_CMD: begin
                        if (!i_status.busy && !o_cmd_req) begin // dropped while busy
                            cmd_index <= i_wdata[5:0];
                            o_cmd_req <= 1'b1;
                        end
                    end
                    `SDCTRL_REG_ARG:     cmd_arg <= i_wdata;
                    default:             ;                  // read-only or unmapped
                endcase
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            sck_cnt  <= '0;
            o_sd_clk <= 1'b0;
        end else begin
            if (sck_tick) begin
                o_sd_clk <= ~o_sd_clk;
            end
            if (sck_tick || div_wr) begin
                sck_cnt <= '0;                          // new half period
            end else if (sck_ena) begin
                sck_cnt <= sck_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            last_resp <= '0;
        end else if (i_resp_valid) begin
            last_resp <= i_resp;                        // timeouts never get here
        end
    end

    // host keeps the access fields while its request waits for ack
    a_req_held: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_req && !o_ack |=> $stable(i_we) && $stable(i_addr) && $stable(i_wdata));

endmodule

// ==== verilog/sdctrl_top.sv ====
/* sd host controller command path: register block, command sequencer,
   transmitter and receiver */
module sdctrl_top (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  logic                  i_req,
    input  logic                  i_we,
    input  sdctrl_pkg::reg_addr_t i_addr,
    input  sdctrl_pkg::reg_data_t i_wdata,
    output logic                  o_ack,
    output sdctrl_pkg::reg_data_t o_rdata,
    output logic                  o_sd_clk,
    output logic                  o_sd_cmd,
    input  logic                  i_sd_cmd
);
    import sdctrl_pkg::*;

    logic        sck_pos;
    logic        sck_neg;
    wdog_t       wdog;
    logic        cmd_req;
    logic        cmd_ack;
    sd_frame_t   cmd_frame;
    cmd_status_t status;
    logic        resp_valid;
    resp_info_t  resp;
    logic        tx_req;
    logic        tx_ack;
    sd_frame_t   tx_frame;
    logic        rx_req;
    logic        rx_ack;
    resp_info_t  rx_resp;
    cmd_err_e    rx_err;

    sdctrl_regs u_regs (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_req(i_req), .i_we(i_we), .i_addr(i_addr), .i_wdata(i_wdata),
        .o_ack(o_ack), .o_rdata(o_rdata), .i_sd_cmd(i_sd_cmd),
        .o_sd_clk(o_sd_clk), .o_sck_pos(sck_pos), .o_sck_neg(sck_neg), .o_wdog(wdog),
        .o_cmd_req(cmd_req), .o_cmd_frame(cmd_frame), .i_cmd_ack(cmd_ack),
        .i_status(status), .i_resp_valid(resp_valid), .i_resp(resp)
    );

    sdctrl_cmd_ctrl u_ctrl (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_cmd_req(cmd_req), .i_cmd_frame(cmd_frame), .o_cmd_ack(cmd_ack),
        .o_status(status), .o_resp_valid(resp_valid), .o_resp(resp),
        .o_tx_req(tx_req), .o_tx_frame(tx_frame), .i_tx_ack(tx_ack),
        .o_rx_req(rx_req), .i_rx_ack(rx_ack), .i_rx_resp(rx_resp), .i_rx_err(rx_err)
    );

    sdctrl_cmd_tx u_tx (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_sck_neg(sck_neg),
        .i_req(tx_req), .i_frame(tx_frame), .o_ack(tx_ack), .o_sd_cmd(o_sd_cmd)
    );

    sdctrl_cmd_rx u_rx (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_sck_pos(sck_pos), .i_sd_cmd(i_sd_cmd),
        .i_wdog(wdog), .i_req(rx_req), .o_ack(rx_ack), .o_resp(rx_resp), .o_err(rx_err)
    );

endmodule
